/* files.f */
+incdir+.
bridge_pkg.sv
uart_rx.sv
uart_tx.sv
frame_parser.sv
bus_master.sv
frame_builder.sv
bridge_ctrl.sv
uart_bridge_top.sv
bridge_checker.sv
tb_uart_bridge.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_uart_bridge -o sim_uart_bridge
./obj_dir/sim_uart_bridge

/* tb_uart_bridge.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module tb_uart_bridge
    import bridge_pkg::*;
;

    localparam int  NUM_ROWS    = 11;
    localparam logic KIND_PLAIN = 1'b0;
    localparam logic KIND_NOISY = 1'b1;   // Junk bytes ahead of the sync byte
    localparam int  CHAR_CYCLES = 10 * `BRIDGE_BIT_CYCLES;
    // Noisy request and its response plus bus timeout and idle gap
    localparam int  ROW_CYCLES  = 24 * CHAR_CYCLES + `BRIDGE_BUS_TIMEOUT + 100;

    typedef struct packed {
        logic    kind;
        byte_t   cmd;
        addr_t   addr;
        word_t   data;
        logic    bad_cks;
        status_t status;
    } row_t;

    logic  clk;
    logic  rst;
    logic  uart_rx;
    logic  uart_tx;
    logic  bus_req;
    logic  bus_we;
    addr_t bus_addr;
    word_t bus_wdata;
    logic  bus_ack;
    word_t bus_rdata;
    logic  busy;
    cnt_t  wr_count;
    cnt_t  rd_count;

    row_t        rows [NUM_ROWS];
    word_t       ref_mem [256];     // Expected register contents
    word_t       bus_mem [256];     // Slave storage
    byte_t       req_q[$];
    byte_t       exp_q[$];
    byte_t       got_q[$];
    int          req_count;
    logic [31:0] lfsr_state;

    uart_bridge_top u_uart_bridge_top (
        .clk       (clk),
        .rst       (rst),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .busy      (busy),
        .wr_count  (wr_count),
        .rd_count  (rd_count)
    );

    bind bridge_ctrl bridge_checker u_bridge_checker (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .start     (start),
        .done      (done),
        .build     (build),
        .frame_ok  (frame_ok),
        .frame_bad (frame_bad)
    );

    always #5 clk = ~clk;

    // Distinct pattern for every register index
    function automatic word_t fill_word(input logic [7:0] idx);
        fill_word = {idx ^ 8'hB0, idx, ~idx, idx ^ 8'h5C};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic fail_check(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Check failed");
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic send_byte(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = bits[i];
            repeat (`BRIDGE_BIT_CYCLES) @(posedge clk);
            #1;
        end
    endtask

    // Samples each bit near its middle on falling edges
    task automatic recv_byte(output byte_t b);
        @(negedge clk);
        while (uart_tx) @(negedge clk);
        repeat (`BRIDGE_BIT_CYCLES / 2 - 1) @(negedge clk);
        assert (!uart_tx) else fail_check("Start bit of a response byte was too short");
        for (int i = 0; i < 8; i++) begin
            repeat (`BRIDGE_BIT_CYCLES) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (`BRIDGE_BIT_CYCLES) @(negedge clk);
        assert (uart_tx) else fail_check("Stop bit of a response byte was low");
    endtask

    task automatic recv_frame(input int n);
        byte_t b;
        got_q = {};
        for (int i = 0; i < n; i++) begin
            recv_byte(b);
            got_q.push_back(b);
        end
    endtask

    // Register bus slave that never answers addresses with bit 15 set
    initial begin
        int    delay;
        logic  we;
        addr_t addr;
        word_t wdata;
        bus_ack    = 1'b0;
        bus_rdata  = '0;
        req_count  = 0;
        lfsr_state = 32'h17dfdf0f;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(8'(i));
        end
        forever begin
            @(negedge clk);
            if (bus_req) begin
                req_count++;
                we    = bus_we;
                addr  = bus_addr;
                wdata = bus_wdata;
                if (!addr[15]) begin
                    take_bits(3, delay);
                    delay = delay + 1;      // 1 to 8 cycles
                    @(posedge clk);
                    repeat (delay - 1) @(posedge clk);
                    #1;
                    if (we) begin
                        bus_mem[addr[7:0]] = wdata;
                    end
                    bus_rdata = bus_mem[addr[7:0]];
                    bus_ack   = 1'b1;
                    @(posedge clk);
                    #1;
                    bus_ack = 1'b0;
                end
            end
        end
    end

    initial begin
        #(10 * (NUM_ROWS * ROW_CYCLES + 100));
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired, the bridge stopped answering");
    end

    initial begin
        row_t  row;
        logic  is_read;
        byte_t cks;
        word_t rd_exp;
        int    first;
        int    reqs_before;
        cnt_t  exp_wr;
        cnt_t  exp_rd;

        clk     = 1'b0;
        rst     = 1'b1;
        uart_rx = 1'b1;
        exp_wr  = '0;
        exp_rd  = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(8'(i));
        end

        //        kind        cmd    addr      data          bad   status
        rows[0]  = '{KIND_PLAIN, 8'h01, 16'h0010, 32'hDEADBEEF, 1'b0, ST_OK};
        rows[1]  = '{KIND_PLAIN, 8'h81, 16'h0010, 32'h00000000, 1'b0, ST_OK};
        rows[2]  = '{KIND_PLAIN, 8'h01, 16'h0020, 32'h12345678, 1'b1, ST_CKSUM};
        rows[3]  = '{KIND_PLAIN, 8'h80, 16'h0020, 32'h00000000, 1'b0, ST_OK};
        rows[4]  = '{KIND_PLAIN, 8'h80, 16'h8004, 32'h00000000, 1'b0, ST_TIMEOUT};
        rows[5]  = '{KIND_PLAIN, 8'h00, 16'h8010, 32'hA5A5A5A5, 1'b0, ST_TIMEOUT};
        rows[6]  = '{KIND_NOISY, 8'h05, 16'h0033, 32'hCAFEF00D, 1'b0, ST_OK};
        rows[7]  = '{KIND_NOISY, 8'h83, 16'h0033, 32'h00000000, 1'b0, ST_OK};
        rows[8]  = '{KIND_PLAIN, 8'h80, 16'h0044, 32'h00000000, 1'b1, ST_CKSUM};
        rows[9]  = '{KIND_PLAIN, 8'h00, 16'h00FF, 32'h00000001, 1'b0, ST_OK};
        rows[10] = '{KIND_PLAIN, 8'h80, 16'h01FF, 32'h00000000, 1'b0, ST_OK};

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (!busy && uart_tx) else fail_check("Bridge not idle after reset");
        assert (wr_count == 0 && rd_count == 0) else fail_check("Counters not zero after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            row     = rows[r];
            is_read = row.cmd[`BRIDGE_READ_BIT];

            req_q = {};
            if (row.kind == KIND_NOISY) begin
                req_q.push_back(8'h3C);
                req_q.push_back(8'h5A);
                req_q.push_back(8'hFF);
            end
            req_q.push_back(`BRIDGE_SYNC_REQ);
            first = req_q.size();
            req_q.push_back(row.cmd);
            req_q.push_back(row.addr[15:8]);
            req_q.push_back(row.addr[7:0]);
            if (!is_read) begin
                for (int k = 3; k >= 0; k--) begin
                    req_q.push_back(row.data[8*k +: 8]);
                end
            end
            cks = '0;
            for (int i = first; i < req_q.size(); i++) begin
                cks ^= req_q[i];
            end
            req_q.push_back(row.bad_cks ? ~cks : cks);

            // Update the reference registers and build the expected response
            if (row.status == ST_OK && !is_read) begin
                ref_mem[row.addr[7:0]] = row.data;
            end
            exp_q = {};
            exp_q.push_back(`BRIDGE_SYNC_RSP);
            exp_q.push_back(row.status);
            exp_q.push_back(row.cmd);
            if (is_read && row.status == ST_OK) begin
                rd_exp = ref_mem[row.addr[7:0]];
                for (int k = 3; k >= 0; k--) begin
                    exp_q.push_back(rd_exp[8*k +: 8]);
                end
            end
            cks = '0;
            for (int i = 1; i < exp_q.size(); i++) begin
                cks ^= exp_q[i];
            end
            exp_q.push_back(cks);

            reqs_before = req_count;
            fork
                begin
                    foreach (req_q[i]) begin
                        send_byte(req_q[i]);
                    end
                end
                recv_frame(exp_q.size());
            join

            for (int i = 0; i < exp_q.size(); i++) begin
                assert (got_q[i] == exp_q[i]) else fail_check($sformatf(
                    "row %0d response byte %0d is %02h, expected %02h",
                    r, i, got_q[i], exp_q[i]));
            end
            if (row.bad_cks) begin
                assert (req_count == reqs_before) else fail_check($sformatf(
                    "row %0d bad checksum still reached the bus", r));
            end else begin
                assert (req_count == reqs_before + 1) else fail_check($sformatf(
                    "row %0d gave %0d bus requests", r, req_count - reqs_before));
            end

            // busy drops two cycles after the last stop bit ends
            repeat (2 * `BRIDGE_BIT_CYCLES) @(posedge clk);
            #1;
            assert (!busy && uart_tx) else fail_check($sformatf(
                "row %0d bridge not idle after the response", r));

            if (row.status == ST_OK) begin
                if (is_read) begin
                    exp_rd++;
                end else begin
                    exp_wr++;
                end
            end
        end

        assert (wr_count == exp_wr) else fail_check($sformatf(
            "wr_count is %0d, expected %0d", wr_count, exp_wr));
        assert (rd_count == exp_rd) else fail_check($sformatf(
            "rd_count is %0d, expected %0d", rd_count, exp_rd));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bridge_checker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module bridge_checker
    import bridge_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ctrl_state_t state,
    input  logic        start,
    input  logic        done,
    input  logic        build,
    input  logic        frame_ok,
    input  logic        frame_bad
);

    localparam logic [7:0] MAX_WAIT = 8'(`BRIDGE_BUS_TIMEOUT + 2);

    logic       pending;        // Bus access in flight
    logic [7:0] wait_cycles;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            wait_cycles <= '0;
        end else if (start) begin
            pending     <= 1'b1;
            wait_cycles <= '0;
        end else if (done) begin
            pending <= 1'b0;
        end else if (pending) begin
            wait_cycles <= wait_cycles + 1'b1;
        end
    end

    start_gets_done: assert property (
        @(posedge clk) disable iff (rst) pending |-> wait_cycles <= MAX_WAIT
    ) else $error("Bus access got no done within the bus timeout");

    build_in_resp: assert property (
        @(posedge clk) disable iff (rst) build |-> state == RESP
    ) else $error("build strobed outside the RESP state");

    ok_bad_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(frame_ok && frame_bad)
    ) else $error("frame_ok and frame_bad high together");

endmodule

`default_nettype wire

/* uart_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module uart_bridge_top
    import bridge_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  uart_rx,
    output logic  uart_tx,
    output logic  bus_req,
    output logic  bus_we,
    output addr_t bus_addr,
    output word_t bus_wdata,
    input  logic  bus_ack,
    input  word_t bus_rdata,
    output logic  busy,
    output cnt_t  wr_count,
    output cnt_t  rd_count
);

    byte_t   rx_byte;
    logic    rx_valid;
    logic    rx_err;
    byte_t   req_cmd;
    addr_t   req_addr;
    word_t   req_wdata;
    logic    frame_ok;
    logic    frame_bad;
    status_t bad_status;
    logic    frame_done;
    logic    start;
    logic    done;
    status_t bus_status;
    word_t   rd_word;
    logic    build;
    status_t rsp_status;
    byte_t   rsp_cmd;
    word_t   rsp_data;
    logic    rsp_has_data;
    logic    rsp_done;
    byte_t   tx_byte;
    logic    tx_start;
    logic    tx_busy;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx_line  (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    frame_parser u_frame_parser (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .rx_err     (rx_err),
        .frame_done (frame_done),
        .req_cmd    (req_cmd),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .frame_ok   (frame_ok),
        .frame_bad  (frame_bad),
        .bad_status (bad_status)
    );

    bridge_ctrl u_bridge_ctrl (
        .clk          (clk),
        .rst          (rst),
        .frame_ok     (frame_ok),
        .frame_bad    (frame_bad),
        .bad_status   (bad_status),
        .req_cmd      (req_cmd),
        .start        (start),
        .done         (done),
        .bus_status   (bus_status),
        .rd_word      (rd_word),
        .build        (build),
        .rsp_status   (rsp_status),
        .rsp_cmd      (rsp_cmd),
        .rsp_data     (rsp_data),
        .rsp_has_data (rsp_has_data),
        .rsp_done     (rsp_done),
        .frame_done   (frame_done),
        .busy         (busy),
        .wr_count     (wr_count),
        .rd_count     (rd_count)
    );

    bus_master u_bus_master (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .we         (!req_cmd[`BRIDGE_READ_BIT]),  // Clear read flag means write
        .addr       (req_addr),
        .wdata      (req_wdata),
        .done       (done),
        .bus_status (bus_status),
        .rd_word    (rd_word),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_ack    (bus_ack),
        .bus_rdata  (bus_rdata)
    );

    frame_builder u_frame_builder (
        .clk          (clk),
        .rst          (rst),
        .build        (build),
        .rsp_status   (rsp_status),
        .rsp_cmd      (rsp_cmd),
        .rsp_data     (rsp_data),
        .rsp_has_data (rsp_has_data),
        .tx_busy      (tx_busy),
        .tx_byte      (tx_byte),
        .tx_start     (tx_start),
        .rsp_done     (rsp_done)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_line  (uart_tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* bridge_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module bridge_ctrl
    import bridge_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    frame_ok,
    input  logic    frame_bad,
    input  status_t bad_status,
    input  byte_t   req_cmd,
    output logic    start,
    input  logic    done,
    input  status_t bus_status,
    input  word_t   rd_word,
    output logic    build,
    output status_t rsp_status,
    output byte_t   rsp_cmd,
    output word_t   rsp_data,
    output logic    rsp_has_data,
    input  logic    rsp_done,
    output logic    frame_done,
    output logic    busy,
    output cnt_t    wr_count,
    output cnt_t    rd_count
);

    ctrl_state_t state;

    always_ff @(posedge clk) begin
        start      <= 1'b0;
        build      <= 1'b0;
        frame_done <= 1'b0;
        if (rst) begin
            state    <= IDLE;
            wr_count <= '0;
            rd_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_ok) begin
                        start <= 1'b1;
                        state <= BUS;
                    end else if (frame_bad) begin
                        rsp_status   <= bad_status;     // Error reply, bus untouched
                        rsp_cmd      <= req_cmd;
                        rsp_has_data <= 1'b0;
                        build        <= 1'b1;
                        state        <= RESP;
                    end
                end
                BUS: begin
                    if (done) begin
                        rsp_status   <= bus_status;
                        rsp_cmd      <= req_cmd;
                        rsp_data     <= rd_word;
                        rsp_has_data <= req_cmd[`BRIDGE_READ_BIT] && bus_status == ST_OK;
                        build        <= 1'b1;
                        state        <= RESP;
                    end
                end
                RESP: state <= WAIT;    // build is high here
                WAIT: begin
                    if (rsp_done) begin
                        frame_done <= 1'b1;
                        state      <= IDLE;
                        // Only completed accesses count
                        if (rsp_status == ST_OK) begin
                            if (rsp_cmd[`BRIDGE_READ_BIT]) begin
                                rd_count <= rd_count + 1'b1;
                            end else begin
                                wr_count <= wr_count + 1'b1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* frame_builder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module frame_builder
    import bridge_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    build,
    input  status_t rsp_status,
    input  byte_t   rsp_cmd,
    input  word_t   rsp_data,
    input  logic    rsp_has_data,
    input  logic    tx_busy,
    output byte_t   tx_byte,
    output logic    tx_start,
    output logic    rsp_done
);

    // Sync, status, cmd, data bytes, then checksum
    localparam logic [3:0] CKS_IDX = 4'(3 + `BRIDGE_DATA_BYTES);

    logic       active;
    logic [3:0] idx;
    byte_t      cks;
    byte_t      next_byte;
    logic       tx_free;

    // tx_busy lags tx_start by one cycle
    assign tx_free = !tx_busy && !tx_start;

    always_comb begin
        case (idx)
            4'd0:    next_byte = `BRIDGE_SYNC_RSP;
            4'd1:    next_byte = rsp_status;
            4'd2:    next_byte = rsp_cmd;
            4'd3:    next_byte = rsp_data[31:24];
            4'd4:    next_byte = rsp_data[23:16];
            4'd5:    next_byte = rsp_data[15:8];
            4'd6:    next_byte = rsp_data[7:0];
            default: next_byte = cks;
        endcase
    end

    always_ff @(posedge clk) begin
        tx_start <= 1'b0;
        rsp_done <= 1'b0;
        if (rst) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (!active) begin
            if (build) begin
                active <= 1'b1;
                idx    <= '0;
                cks    <= '0;
            end
        end else if (tx_free) begin
            if (idx > CKS_IDX) begin
                active   <= 1'b0;   // Checksum has left the transmitter
                rsp_done <= 1'b1;
            end else begin
                tx_byte  <= next_byte;
                tx_start <= 1'b1;
                if (idx != 4'd0) begin
                    cks <= cks ^ next_byte;
                end
                idx <= (idx == 4'd2 && !rsp_has_data) ? CKS_IDX : idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bus_master.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module bus_master
    import bridge_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    we,
    input  addr_t   addr,
    input  word_t   wdata,
    output logic    done,
    output status_t bus_status,
    output word_t   rd_word,
    output logic    bus_req,
    output logic    bus_we,
    output addr_t   bus_addr,
    output word_t   bus_wdata,
    input  logic    bus_ack,
    input  word_t   bus_rdata
);

    localparam int TOW = $clog2(`BRIDGE_BUS_TIMEOUT + 1);
    localparam logic [TOW-1:0] LAST_WAIT = TOW'(`BRIDGE_BUS_TIMEOUT - 1);

    logic           waiting;
    logic [TOW-1:0] wait_cnt;

    // Request goes out in the start cycle, fields are held by the parser
    assign bus_req   = start;
    assign bus_we    = we;
    assign bus_addr  = addr;
    assign bus_wdata = wdata;

    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (rst) begin
            waiting  <= 1'b0;
            wait_cnt <= '0;
        end else if (start) begin
            waiting  <= 1'b1;
            wait_cnt <= '0;
        end else if (waiting) begin
            if (bus_ack) begin
                rd_word    <= bus_rdata;
                bus_status <= ST_OK;
                done       <= 1'b1;
                waiting    <= 1'b0;
            end else if (wait_cnt == LAST_WAIT) begin
                bus_status <= ST_TIMEOUT;   // A later ack is ignored
                done       <= 1'b1;
                waiting    <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* frame_parser.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module frame_parser
    import bridge_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  byte_t   rx_byte,
    input  logic    rx_valid,
    input  logic    rx_err,
    input  logic    frame_done,
    output byte_t   req_cmd,
    output addr_t   req_addr,
    output word_t   req_wdata,
    output logic    frame_ok,
    output logic    frame_bad,
    output status_t bad_status
);

    localparam logic [1:0] LAST_DATA = 2'(`BRIDGE_DATA_BYTES - 1);

    parse_state_t state;
    byte_t        cks;          // XOR of bytes after sync
    logic [1:0]   data_cnt;

    always_ff @(posedge clk) begin
        frame_ok  <= 1'b0;
        frame_bad <= 1'b0;
        if (rst) begin
            state <= PS_SYNC;
        end else if (state == PS_HOLD) begin
            // Everything on the line is dropped until the response is out
            if (frame_done) begin
                state <= PS_SYNC;
            end
        end else if (rx_err && state != PS_SYNC) begin
            frame_bad  <= 1'b1;
            bad_status <= ST_FRAMING;
            state      <= PS_HOLD;
        end else if (rx_valid) begin
            case (state)
                PS_SYNC: begin
                    if (rx_byte == `BRIDGE_SYNC_REQ) begin  // Noise bytes skipped
                        cks     <= '0;
                        req_cmd <= '0;
                        state   <= PS_CMD;
                    end
                end
                PS_CMD: begin
                    req_cmd <= rx_byte;
                    cks     <= cks ^ rx_byte;
                    state   <= PS_ADDR_H;
                end
                PS_ADDR_H: begin
                    req_addr[15:8] <= rx_byte;
                    cks            <= cks ^ rx_byte;
                    state          <= PS_ADDR_L;
                end
                PS_ADDR_L: begin
                    req_addr[7:0] <= rx_byte;
                    cks           <= cks ^ rx_byte;
                    data_cnt      <= '0;
                    // Reads carry no data bytes
                    state <= req_cmd[`BRIDGE_READ_BIT] ? PS_CKSUM : PS_DATA;
                end
                PS_DATA: begin
                    req_wdata <= {req_wdata[23:0], rx_byte};  // MSB first
                    cks       <= cks ^ rx_byte;
                    data_cnt  <= data_cnt + 1'b1;
                    if (data_cnt == LAST_DATA) begin
                        state <= PS_CKSUM;
                    end
                end
                PS_CKSUM: begin
                    if (rx_byte == cks) begin
                        frame_ok <= 1'b1;
                    end else begin
                        frame_bad  <= 1'b1;
                        bad_status <= ST_CKSUM;
                    end
                    state <= PS_HOLD;
                end
                default: state <= PS_SYNC;
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module uart_tx
    import bridge_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  tx_line,
    output logic  tx_busy
);

    localparam int TW = $clog2(`BRIDGE_BIT_CYCLES);
    localparam logic [TW-1:0] FULL_BIT = TW'(`BRIDGE_BIT_CYCLES - 1);

    logic [9:0]    shift;       // Stop, data, start
    logic [3:0]    bit_idx;
    logic [TW-1:0] timer;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_line <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
            timer   <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift   <= {1'b1, tx_byte, 1'b0};
                tx_line <= 1'b0;
                tx_busy <= 1'b1;
                bit_idx <= '0;
                timer   <= FULL_BIT;
            end
        end else if (timer != '0) begin
            timer <= timer - 1'b1;
        end else if (bit_idx == 4'd9) begin
            tx_busy <= 1'b0;    // Stop bit done, line stays high
        end else begin
            shift   <= {1'b1, shift[9:1]};
            tx_line <= shift[1];
            bit_idx <= bit_idx + 1'b1;
            timer   <= FULL_BIT;
        end
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "bridge_defs.svh"

module uart_rx
    import bridge_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rx_line,
    output byte_t rx_byte,
    output logic  rx_valid,
    output logic  rx_err
);

    localparam int TW = $clog2(`BRIDGE_BIT_CYCLES);
    localparam logic [TW-1:0] HALF_BIT = TW'(`BRIDGE_BIT_CYCLES / 2 - 1);
    localparam logic [TW-1:0] FULL_BIT = TW'(`BRIDGE_BIT_CYCLES - 1);

    logic [1:0]    sync_q;
    logic          line_s;
    logic          active;
    logic [3:0]    bit_idx;     // 0 start, 1..8 data, 9 stop
    logic [TW-1:0] timer;

    assign line_s = sync_q[1];

    always_ff @(posedge clk) begin
        rx_valid <= 1'b0;
        rx_err   <= 1'b0;
        if (rst) begin
            sync_q  <= 2'b11;   // Line idles high
            active  <= 1'b0;
            bit_idx <= '0;
            timer   <= '0;
        end else begin
            sync_q <= {sync_q[0], rx_line};
            if (!active) begin
                if (!line_s) begin  // Start edge
                    active  <= 1'b1;
                    bit_idx <= '0;
                    timer   <= HALF_BIT;
                end
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end else begin
                timer <= FULL_BIT;
                if (bit_idx == 4'd0) begin
                    // Start bit must still be low at mid-bit
                    if (line_s) begin
                        active <= 1'b0;
                    end else begin
                        bit_idx <= 4'd1;
                    end
                end else if (bit_idx <= 4'd8) begin
                    rx_byte <= {line_s, rx_byte[7:1]};  // LSB first
                    bit_idx <= bit_idx + 1'b1;
                end else begin
                    active   <= 1'b0;
                    rx_valid <= line_s;
                    rx_err   <= !line_s;    // Missing stop bit
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    typedef logic [7:0]  byte_t;    // Serial character
    typedef logic [15:0] addr_t;    // Register bus address
    typedef logic [31:0] word_t;    // Register data
    typedef logic [15:0] cnt_t;     // Statistics counter
    typedef logic [7:0]  status_t;  // Response status code

    localparam status_t ST_OK      = 8'h00;
    localparam status_t ST_CKSUM   = 8'h01;
    localparam status_t ST_TIMEOUT = 8'h02;
    localparam status_t ST_FRAMING = 8'h03;

    // Request parser
    typedef enum logic [2:0] {
        PS_SYNC,
        PS_CMD,
        PS_ADDR_H,
        PS_ADDR_L,
        PS_DATA,
        PS_CKSUM,
        PS_HOLD     // Frame reported, waiting for frame_done
    } parse_state_t;

    // Central sequencer
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        RESP,
        WAIT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// UART timing, fixed clocks per bit
`define BRIDGE_BIT_CYCLES   16

// Frame layout
`define BRIDGE_SYNC_REQ     8'hA5   // Host to bridge
`define BRIDGE_SYNC_RSP     8'h5A   // Bridge to host
`define BRIDGE_DATA_BYTES   4       // One 32-bit word, MSB first
`define BRIDGE_READ_BIT     7       // Read flag in the cmd byte

// Cycles to wait for bus_ack after bus_req
`define BRIDGE_BUS_TIMEOUT  64

`endif
